/* Bender.yml */
package:
  name: mbank

sources:
  - files:
      - hw/mbank_pkg.sv
      - hw/wr_arbiter.sv
      - hw/rd_pipe.sv
      - hw/bank_mux.sv
      - hw/mem_bank.sv
      - hw/mbank_top.sv
  - target: test
    files:
      - bench/mbank_asserts.sv
      - bench/tb_mbank.sv

/* bench/mbank_asserts.sv */
`timescale 1ns/1ns

module mbank_asserts #(
  parameter int NUMWRPT    = 2,
  parameter int NUMPBNK    = 11,
  parameter int DRAM_DELAY = 2
) (
  input logic                 clk,
  input logic                 arst_n,
  input mbank_pkg::rd_req_t   rd_req,
  input mbank_pkg::wr_req_t   wr_req [NUMWRPT],
  input logic [NUMWRPT-1:0]   wr_accept,
  input mbank_pkg::bank_cmd_t bank_cmd [NUMPBNK],
  input mbank_pkg::rd_rsp_t   rd_rsp
);

  int unsigned fail_count = 0;  // failed assertion attempts.

  for (genvar b = 0; b < NUMPBNK; b++) begin : g_bank
    a_one_cmd: assert property (@(posedge clk) disable iff (!arst_n)
      !(bank_cmd[b].read && bank_cmd[b].write))
      else begin
        $error("bank %0d got a read and a write in one cycle", b);
        fail_count++;
      end
  end

  for (genvar i = 0; i < NUMWRPT; i++) begin : g_port
    a_read_first: assert property (@(posedge clk) disable iff (!arst_n)
      !(rd_req.valid && wr_accept[i] && (wr_req[i].bank == rd_req.bank)))
      else begin
        $error("write port %0d accepted on the bank being read", i);
        fail_count++;
      end
  end

  a_rsp_delay: assert property (@(posedge clk) disable iff (!arst_n)
    rd_rsp.valid == $past(rd_req.valid, DRAM_DELAY))
    else begin
      $error("rd_rsp.valid does not follow rd_req.valid by %0d cycles", DRAM_DELAY);
      fail_count++;
    end

endmodule

bind mbank_top mbank_asserts #(
  .NUMWRPT    (NUMWRPT),
  .NUMPBNK    (NUMPBNK),
  .DRAM_DELAY (DRAM_DELAY)
) asserts_i (
  .clk       (clk),
  .arst_n    (arst_n),
  .rd_req    (rd_req),
  .wr_req    (wr_req),
  .wr_accept (wr_accept),
  .bank_cmd  (bank_cmd),
  .rd_rsp    (rd_rsp)
);

/* bench/tb_mbank.sv */
`timescale 1ns/1ns

module tb_mbank;

  localparam int NUMWRPT       = 2;
  localparam int NUMPBNK       = 11;
  localparam int DRAM_DELAY    = 2;
  localparam int RANDOM_CYCLES = 400;
  localparam int NUMPADR       = 2 ** mbank_pkg::BITPADR;
  // reset, directed tests, random mix, then a margin.
  localparam int CYCLE_LIMIT   = 4 + 25 + 10 + 8 + 28 + 20 + RANDOM_CYCLES + 200;

  typedef struct {
    mbank_pkg::rd_rsp_t rsp;
    int                 due;
    bit                 known;
  } exp_rsp_t;

  logic               clk;
  logic               arst_n;
  mbank_pkg::rd_req_t rd_req;
  mbank_pkg::wr_req_t wr_req [NUMWRPT];
  logic [NUMWRPT-1:0] wr_accept;
  mbank_pkg::rd_rsp_t rd_rsp;

  mbank_pkg::data_t shadow     [NUMPADR];
  bit               shadow_vld [NUMPADR];
  exp_rsp_t         exp_q      [$];
  mbank_pkg::padr_t addr_q     [$];

  logic [31:0] lcg_state = 32'h6ae2a9a8;
  int          cyc       = 0;
  int          errors    = 0;
  int          checks    = 0;
  int          tests     = 0;
  int          test_err0;
  string       test_name;

  mbank_top #(
    .NUMWRPT    (NUMWRPT),
    .NUMPBNK    (NUMPBNK),
    .DRAM_DELAY (DRAM_DELAY)
  ) dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .wr_accept (wr_accept),
    .rd_rsp    (rd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    wait (cyc > CYCLE_LIMIT);
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test FAILED");
    $finish;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:8];  // low bits of an lcg are weak.
  endfunction

  function automatic mbank_pkg::data_t rand_word();
    mbank_pkg::data_t w;
    w = mbank_pkg::data_t'(next_rand());
    w = (w << 8) ^ mbank_pkg::data_t'(next_rand());  // fills all 32 bits.
    return w;
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_accept(input logic [NUMWRPT-1:0] got, input logic [NUMWRPT-1:0] exp);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("wr_accept %b, expected %b", got, exp));
    end
  endtask

  task automatic check_rsp(input mbank_pkg::rd_rsp_t got, input mbank_pkg::rd_rsp_t exp);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("rd_rsp valid %b data %h padr %h, expected valid %b data %h padr %h",
                             got.valid, got.data, got.padr, exp.valid, exp.data, exp.padr));
    end
  endtask

  task automatic clear_inputs();
    rd_req = '0;
    for (int i = 0; i < NUMWRPT; i++) begin
      wr_req[i] = '0;
    end
  endtask

  task automatic set_read(input mbank_pkg::bank_t b, input mbank_pkg::row_t r);
    rd_req.valid = 1'b1;
    rd_req.bank  = b;
    rd_req.row   = r;
  endtask

  task automatic set_write(input int p, input mbank_pkg::bank_t b, input mbank_pkg::row_t r,
                           input mbank_pkg::data_t d);
    wr_req[p].valid = 1'b1;
    wr_req[p].bank  = b;
    wr_req[p].row   = r;
    wr_req[p].data  = d;
  endtask

  // One cycle. Predicts the grants, checks what is due, updates the model.
  task automatic step();
    logic [NUMWRPT-1:0] exp_acc;
    logic [15:0]        taken;
    exp_rsp_t           e;
    mbank_pkg::rd_rsp_t want;
    mbank_pkg::padr_t   a;
    #10;
    taken   = '0;
    exp_acc = '0;
    if (rd_req.valid) begin
      taken[rd_req.bank] = 1'b1;  // read claims first.
    end
    for (int i = 0; i < NUMWRPT; i++) begin
      if (wr_req[i].valid && !taken[wr_req[i].bank]) begin
        exp_acc[i]            = 1'b1;
        taken[wr_req[i].bank] = 1'b1;
      end
    end
    check_accept(wr_accept, exp_acc);
    if ((exp_q.size() > 0) && (exp_q[0].due == cyc)) begin
      e    = exp_q.pop_front();
      want = e.rsp;
      if (!e.known) begin
        want.data = rd_rsp.data;  // unwritten word.
      end
      check_rsp(rd_rsp, want);
    end else if (rd_rsp.valid !== 1'b0) begin
      report_error($sformatf("unexpected read response for padr %h", rd_rsp.padr));
    end
    if (rd_req.valid) begin
      a           = {rd_req.bank, rd_req.row};
      e.rsp.valid = 1'b1;
      e.rsp.data  = shadow[a];
      e.rsp.padr  = a;
      e.due       = cyc + DRAM_DELAY;
      e.known     = shadow_vld[a];
      exp_q.push_back(e);
    end
    for (int i = 0; i < NUMWRPT; i++) begin
      if (exp_acc[i]) begin
        a             = {wr_req[i].bank, wr_req[i].row};
        shadow[a]     = wr_req[i].data;
        shadow_vld[a] = 1'b1;
      end
    end
    @(posedge clk);
    #2;
    clear_inputs();
  endtask

  task automatic drain();
    while (exp_q.size() > 0) begin
      step();
    end
    step();  // nothing extra may follow.
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %0d, %s: finished with %0d errors", tests, test_name, errors - test_err0);
  endtask

  initial begin
    mbank_pkg::bank_t b;
    mbank_pkg::padr_t a;
    arst_n = 1'b0;
    clear_inputs();
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;

    begin_test("write then read");
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < NUMWRPT; p++) begin
        b = mbank_pkg::bank_t'((k * NUMWRPT + p) % NUMPBNK);
        set_write(p, b, mbank_pkg::row_t'(k), rand_word());
        addr_q.push_back({b, mbank_pkg::row_t'(k)});
      end
      step();
    end
    while (addr_q.size() > 0) begin
      a = addr_q.pop_front();
      set_read(a[mbank_pkg::BITVROW +: mbank_pkg::BITPBNK], a[mbank_pkg::BITVROW-1:0]);
      step();
    end
    drain();
    end_test();

    begin_test("read over write");
    set_write(0, 4'd3, 10'd5, rand_word());
    set_write(1, 4'd4, 10'd6, rand_word());
    step();
    set_read(4'd3, 10'd5);
    set_write(0, 4'd3, 10'd5, rand_word());  // both lose to the read.
    set_write(1, 4'd3, 10'd9, rand_word());
    step();
    set_read(4'd3, 10'd5);
    step();
    drain();
    end_test();

    begin_test("port priority");
    set_write(0, 4'd7, 10'd2, rand_word());
    set_write(1, 4'd7, 10'd2, rand_word());
    step();
    set_read(4'd7, 10'd2);
    step();
    drain();
    end_test();

    begin_test("back-to-back reads");
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < NUMWRPT; p++) begin
        if (k * NUMWRPT + p < NUMPBNK) begin
          set_write(p, mbank_pkg::bank_t'(k * NUMWRPT + p), 10'd1, rand_word());
        end
      end
      step();
    end
    for (int k = 0; k < 16; k++) begin
      set_read(mbank_pkg::bank_t'((k * 4 + 1) % NUMPBNK), 10'd1);
      step();
    end
    drain();
    end_test();

    begin_test("random mix");
    for (int k = 0; k < RANDOM_CYCLES; k++) begin
      if (next_rand() % 2 == 0) begin
        set_read(mbank_pkg::bank_t'(next_rand() % NUMPBNK), mbank_pkg::row_t'(next_rand() % 8));
      end
      for (int p = 0; p < NUMWRPT; p++) begin
        if (next_rand() % 2 == 0) begin
          set_write(p, mbank_pkg::bank_t'(next_rand() % NUMPBNK),
                    mbank_pkg::row_t'(next_rand() % 8), rand_word());
        end
      end
      step();
    end
    drain();
    end_test();

    begin_test("reset");
    for (int k = 0; k <= DRAM_DELAY; k++) begin
      set_read(mbank_pkg::bank_t'(k % NUMPBNK), 10'd0);
      step();
    end
    #1;
    checks++;
    if (rd_rsp.valid !== 1'b1) begin
      report_error("no read response was in flight when reset was applied");
    end
    arst_n = 1'b0;
    #1;
    checks++;
    if (rd_rsp.valid !== 1'b0) begin
      report_error("rd_rsp.valid did not drop when reset was asserted");
    end
    exp_q.delete();
    foreach (shadow_vld[i]) shadow_vld[i] = 1'b0;  // contents undefined after reset.
    repeat (3) begin
      @(posedge clk);
      #2;
      checks++;
      if (rd_rsp.valid !== 1'b0) begin
        report_error("rd_rsp.valid went high during reset");
      end
    end
    arst_n = 1'b1;
    repeat (DRAM_DELAY + 3) step();
    end_test();

    if (dut_i.asserts_i.fail_count != 0) begin
      $display("%0d bound assertion failures", dut_i.asserts_i.fail_count);
      errors += int'(dut_i.asserts_i.fail_count);
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
hw/mbank_pkg.sv
hw/wr_arbiter.sv
hw/rd_pipe.sv
hw/bank_mux.sv
hw/mem_bank.sv
hw/mbank_top.sv
bench/mbank_asserts.sv
bench/tb_mbank.sv

/* hw/bank_mux.sv */
`timescale 1ns/1ns

module bank_mux #(
  parameter int NUMWRPT = 2,
  parameter int NUMPBNK = 11
) (
  input  mbank_pkg::rd_req_t   rd_req,
  input  mbank_pkg::wr_req_t   wr_req [NUMWRPT],
  input  logic [NUMWRPT-1:0]   wr_accept,
  input  logic                 rsp_valid,
  input  mbank_pkg::padr_t     rsp_padr,
  input  mbank_pkg::data_t     bank_dout [NUMPBNK],
  output mbank_pkg::bank_cmd_t bank_cmd [NUMPBNK],
  output mbank_pkg::rd_rsp_t   rd_rsp
);

  mbank_pkg::bank_t rsp_bank;
  mbank_pkg::data_t rsp_data;

  // Scatter. The arbiter guarantees at most one hit per bank, so the
  // read and write terms below never overlap on the same bank.
  always_comb begin
    for (int b = 0; b < NUMPBNK; b++) begin
      bank_cmd[b] = '0;
      if (rd_req.valid && (rd_req.bank == mbank_pkg::bank_t'(b))) begin
        bank_cmd[b].read = 1'b1;
        bank_cmd[b].row  = rd_req.row;
      end
      for (int i = 0; i < NUMWRPT; i++) begin
        if (wr_accept[i] && (wr_req[i].bank == mbank_pkg::bank_t'(b))) begin
          bank_cmd[b].write = 1'b1;
          bank_cmd[b].row   = wr_req[i].row;
          bank_cmd[b].din   = wr_req[i].data;
        end
      end
    end
  end

  assign rsp_bank = rsp_padr[mbank_pkg::BITVROW +: mbank_pkg::BITPBNK];

  // gather from the bank named in the delayed address.
  always_comb begin
    rsp_data = '0;
    for (int b = 0; b < NUMPBNK; b++) begin
      if (rsp_bank == mbank_pkg::bank_t'(b)) begin
        rsp_data = bank_dout[b];
      end
    end
  end

  always_comb begin
    rd_rsp.valid = rsp_valid;
    rd_rsp.data  = rsp_data;
    rd_rsp.padr  = rsp_padr;  // full physical address.
  end

endmodule

/* hw/mbank_pkg.sv */
package mbank_pkg;

  localparam int WIDTH   = 32;
  localparam int BITVROW = 10;
  localparam int BITPBNK = 4;   // up to 16 banks.
  localparam int BITPADR = BITPBNK + BITVROW;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [BITVROW-1:0] row_t;
  typedef logic [BITPBNK-1:0] bank_t;
  typedef logic [BITPADR-1:0] padr_t;  // bank above row.

  typedef struct packed {
    logic  valid;
    bank_t bank;
    row_t  row;
    data_t data;
  } wr_req_t;

  typedef struct packed {
    logic  valid;
    bank_t bank;
    row_t  row;
  } rd_req_t;

  // one request per bank per cycle, so read and write never both set.
  typedef struct packed {
    logic  read;
    logic  write;
    row_t  row;
    data_t din;
  } bank_cmd_t;

  typedef struct packed {
    logic  valid;
    data_t data;
    padr_t padr;
  } rd_rsp_t;

endpackage

/* hw/mbank_top.sv */
`timescale 1ns/1ns

module mbank_top #(
  parameter int NUMWRPT    = 2,
  parameter int NUMPBNK    = 11,  // at most 16.
  parameter int DRAM_DELAY = 2    // at least 1.
) (
  input  logic                clk,
  input  logic                arst_n,
  input  mbank_pkg::rd_req_t  rd_req,
  input  mbank_pkg::wr_req_t  wr_req [NUMWRPT],
  output logic [NUMWRPT-1:0]  wr_accept,
  output mbank_pkg::rd_rsp_t  rd_rsp
);

  logic                 rsp_valid;
  mbank_pkg::padr_t     rsp_padr;
  mbank_pkg::bank_cmd_t bank_cmd  [NUMPBNK];
  mbank_pkg::data_t     bank_dout [NUMPBNK];

  wr_arbiter #(
    .NUMWRPT   (NUMWRPT),
    .NUMPBNK   (NUMPBNK)
  ) arb_i (
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .wr_accept (wr_accept)
  );

  rd_pipe #(
    .DRAM_DELAY (DRAM_DELAY)
  ) pipe_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_req    (rd_req),
    .rsp_valid (rsp_valid),
    .rsp_padr  (rsp_padr)
  );

  bank_mux #(
    .NUMWRPT   (NUMWRPT),
    .NUMPBNK   (NUMPBNK)
  ) mux_i (
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .wr_accept (wr_accept),
    .rsp_valid (rsp_valid),
    .rsp_padr  (rsp_padr),
    .bank_dout (bank_dout),
    .bank_cmd  (bank_cmd),
    .rd_rsp    (rd_rsp)
  );

  for (genvar b = 0; b < NUMPBNK; b++) begin : g_bank
    mem_bank #(
      .DRAM_DELAY (DRAM_DELAY)
    ) bank_i (
      .clk    (clk),
      .arst_n (arst_n),
      .cmd    (bank_cmd[b]),
      .dout   (bank_dout[b])
    );
  end

endmodule

/* hw/mem_bank.sv */
`timescale 1ns/1ns

module mem_bank #(
  parameter int DRAM_DELAY = 2
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  mbank_pkg::bank_cmd_t cmd,
  output mbank_pkg::data_t     dout
);

  localparam int NUMVROW = 2 ** mbank_pkg::BITVROW;

  mbank_pkg::data_t mem [NUMVROW];

  logic [DRAM_DELAY-1:0] stg_vld;  // which output stages hold a fresh word.
  mbank_pkg::data_t      stg_data [DRAM_DELAY];

  // single port, so a cycle is either a write or a read.
  always_ff @(posedge clk) begin
    if (cmd.write) begin
      mem[cmd.row] <= cmd.din;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stg_vld <= '0;
    end else begin
      stg_vld[0] <= cmd.read;
      for (int i = 1; i < DRAM_DELAY; i++) begin
        stg_vld[i] <= stg_vld[i-1];
      end
    end
  end

  // First stage captures the array word. Later stages only move
  // when a word is behind them, so idle cycles leave them quiet.
  always_ff @(posedge clk) begin
    if (cmd.read) begin
      stg_data[0] <= mem[cmd.row];
    end
    for (int i = 1; i < DRAM_DELAY; i++) begin
      if (stg_vld[i-1]) begin
        stg_data[i] <= stg_data[i-1];
      end
    end
  end

  assign dout = stg_data[DRAM_DELAY-1];

endmodule

/* hw/rd_pipe.sv */
`timescale 1ns/1ns

module rd_pipe #(
  parameter int DRAM_DELAY = 2
) (
  input  logic                clk,
  input  logic                arst_n,
  input  mbank_pkg::rd_req_t  rd_req,
  output logic                rsp_valid,
  output mbank_pkg::padr_t    rsp_padr
);

  logic [DRAM_DELAY-1:0] vld_q;
  mbank_pkg::padr_t      padr_q [DRAM_DELAY];

  // valids need a clean start after reset.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= rd_req.valid;
      for (int i = 1; i < DRAM_DELAY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // address tag follows its valid stage by stage.
  always_ff @(posedge clk) begin
    padr_q[0] <= {rd_req.bank, rd_req.row};
    for (int i = 1; i < DRAM_DELAY; i++) begin
      padr_q[i] <= padr_q[i-1];
    end
  end

  assign rsp_valid = vld_q[DRAM_DELAY-1];
  assign rsp_padr  = padr_q[DRAM_DELAY-1];

endmodule

/* hw/wr_arbiter.sv */
`timescale 1ns/1ns

module wr_arbiter #(
  parameter int NUMWRPT = 2,
  parameter int NUMPBNK = 11
) (
  input  mbank_pkg::rd_req_t  rd_req,
  input  mbank_pkg::wr_req_t  wr_req [NUMWRPT],
  output logic [NUMWRPT-1:0]  wr_accept
);

  logic [NUMPBNK-1:0] claimed;     // banks taken this cycle.
  logic [NUMPBNK-1:0] rd_claim;
  logic [NUMWRPT-1:0] wr_in_range;

  // read has first claim on its bank.
  always_comb begin
    rd_claim = '0;
    if (rd_req.valid && (rd_req.bank < NUMPBNK)) begin
      rd_claim[rd_req.bank] = 1'b1;
    end
  end

  // writes to a bank that does not exist are never accepted.
  always_comb begin
    for (int i = 0; i < NUMWRPT; i++) begin
      wr_in_range[i] = wr_req[i].bank < NUMPBNK;
    end
  end

  // Write ports are walked lowest index first. A port wins only if
  // nobody ahead of it, read included, has taken the bank yet.
  always_comb begin
    claimed   = rd_claim;
    wr_accept = '0;
    for (int i = 0; i < NUMWRPT; i++) begin
      if (wr_req[i].valid && wr_in_range[i]) begin
        if (!claimed[wr_req[i].bank]) begin
          wr_accept[i]             = 1'b1;
          claimed[wr_req[i].bank]  = 1'b1;  // later ports lose this bank.
        end
      end
    end
  end

endmodule
